/* rtl/fetch_cfg.svh */
// ----------------------------------------------------------
// Sizing macros for the fetch unit
// Both queues take FETCH_MAX_IN_FLIGHT as their depth
// Epoch tag width bounds how many squashes can stack up
// ----------------------------------------------------------
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// Outstanding memory reads, also depth of both queues
`define FETCH_MAX_IN_FLIGHT 8

// Sequence number width, 2^N live instructions at most
`define FETCH_SEQ_NUM_BITS 4

// Opaque tag width, carries the fetch epoch
`define FETCH_OPAQ_BITS 2

// First fetch address after reset
`define FETCH_RESET_PC 32'h0000_0200

`endif

/* rtl/mem_pkg.sv */
// ----------------------------------------------------------
// Instruction memory message types
// Word reads only, responses must come back in request order
// No error field, the memory is assumed to always answer
// ----------------------------------------------------------
`include "fetch_cfg.svh"

package mem_pkg;

  // ----------------------------------------------------------
  // Request, fetch unit to memory
  // ----------------------------------------------------------

  typedef struct packed {
    // Word-aligned byte address
    logic [31:0]                 addr;
    // Returned untouched in the response
    logic [`FETCH_OPAQ_BITS-1:0] opaque;
  } mem_req_t;

  // ----------------------------------------------------------
  // Response, memory to fetch unit
  // ----------------------------------------------------------

  typedef struct packed {
    // Instruction word
    logic [31:0]                 data;
    // Copy of the request tag
    logic [`FETCH_OPAQ_BITS-1:0] opaque;
  } mem_resp_t;

endpackage

/* rtl/fetch_pkg.sv */
// ----------------------------------------------------------
// Fetch-side message types
// Sequence numbers wrap, live range is tracked in delivery
// Commit carries only the sequence number
// ----------------------------------------------------------
`include "fetch_cfg.svh"

package fetch_pkg;

  // Wrapping instruction tag
  typedef logic [`FETCH_SEQ_NUM_BITS-1:0] seq_num_t;

  // Fetch epoch, bumped on every squash
  typedef logic [`FETCH_OPAQ_BITS-1:0] epoch_t;

  // ----------------------------------------------------------
  // Fetch to decode
  // ----------------------------------------------------------

  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
    seq_num_t    seq_num;
  } f_d_msg_t;

  // ----------------------------------------------------------
  // Squash notification
  // ----------------------------------------------------------

  typedef struct packed {
    // Squashing instruction, stays live
    seq_num_t    seq_num;
    // New fetch address
    logic [31:0] target;
  } squash_msg_t;

  // One issued request still waiting for its data
  typedef struct packed {
    logic [31:0] pc;
    epoch_t      epoch;
  } pending_t;

endpackage

/* rtl/fetch_queue.sv */
// ----------------------------------------------------------
// Synchronous FIFO, registered output, no bypass
// Push when full and pop when empty are dropped
// Storage has no reset, only pointers and count do
// ----------------------------------------------------------
`timescale 1ns/1ps

module fetch_queue #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 8
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  // Pointer wide enough for DEPTH entries, count reaches DEPTH
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  // Wrap at DEPTH, not at the power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty   = (count == '0);
  assign full    = (count == CNT_W'(DEPTH));
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // Head entry always visible
  assign pop_data = mem[rd_ptr];

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // ----------------------------------------------------------
  // Pointers and occupancy
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (do_pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Simultaneous push and pop leaves count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

/* rtl/fetch_pc_gen.sv */
// ----------------------------------------------------------
// Sequential PC generation and memory request issue
// Issue stops while the pending queue is full
// A squash masks the request and redirects at the same edge
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_pc_gen (
  input  logic                   clk,
  input  logic                   rst_n,
  output mem_pkg::mem_req_t      mem_req,
  output logic                   mem_req_val,
  input  logic                   mem_req_rdy,
  input  logic                   pend_full,
  output logic                   pend_push,
  output fetch_pkg::pending_t    pend_data,
  input  logic                   squash_val,
  input  fetch_pkg::squash_msg_t squash,
  output fetch_pkg::epoch_t      epoch
);

  import fetch_pkg::*;

  // Address of the next request to go out
  logic [31:0] pc_q;
  // Current epoch, tags every request
  epoch_t      epoch_q;
  // Set one edge after reset release
  logic        issue_en;
  // Request handshake completes this cycle
  logic        req_fire;

  // ----------------------------------------------------------
  // Request channel
  // ----------------------------------------------------------

  // Full can only fall while val waits, so val never drops early
  assign mem_req_val    = issue_en && !pend_full && !squash_val;
  assign req_fire       = mem_req_val && mem_req_rdy;
  assign mem_req.addr   = pc_q;
  assign mem_req.opaque = epoch_q;

  // Record of the request, paired with its response later
  assign pend_push       = req_fire;
  assign pend_data.pc    = pc_q;
  assign pend_data.epoch = epoch_q;

  // Delivery compares pending epochs against this
  assign epoch = epoch_q;

  // ----------------------------------------------------------
  // PC and epoch registers
  // ----------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_en <= 1'b0;
      pc_q     <= `FETCH_RESET_PC;
      epoch_q  <= '0;
    end else begin
      issue_en <= 1'b1;
      if (squash_val) begin
        // Redirect, older requests become stale
        pc_q    <= squash.target;
        epoch_q <= epoch_q + 1'b1;
      end else if (req_fire) begin
        // Next sequential word
        pc_q <= pc_q + 32'd4;
      end
    end
  end

endmodule

/* rtl/fetch_deliver.sv */
// ----------------------------------------------------------
// Pairs responses with pending PCs and feeds decode
// Stale pairs are dropped one per cycle, never shown to decode
// Commits must retire the oldest live number, in order
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_deliver (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   resp_empty,
  input  logic                   pend_empty,
  input  mem_pkg::mem_resp_t     resp_data,
  input  fetch_pkg::pending_t    pend_data,
  output logic                   pop,
  input  fetch_pkg::epoch_t      epoch,
  output fetch_pkg::f_d_msg_t    d_msg,
  output logic                   d_val,
  input  logic                   d_rdy,
  input  logic                   commit_val,
  input  fetch_pkg::seq_num_t    commit_seq_num,
  input  logic                   squash_val,
  input  fetch_pkg::squash_msg_t squash
);

  import fetch_pkg::*;

  localparam int NUM_SEQ = 2 ** `FETCH_SEQ_NUM_BITS;
  // One extra bit so a full sequence space is visible
  localparam int CNT_W   = `FETCH_SEQ_NUM_BITS + 1;

  // Oldest live number
  seq_num_t         head_q;
  // Next number to hand out
  seq_num_t         tail_q;
  logic [CNT_W-1:0] live_cnt;
  // Distance of the squashing number from the head
  seq_num_t         sq_dist;
  logic [CNT_W-1:0] live_sq;
  logic             pair_avail;
  logic             stale;
  logic             seq_full;
  logic             accept;

  // ----------------------------------------------------------
  // Head pair and decode handshake
  // ----------------------------------------------------------

  // Both queues move together, so one empty is enough in practice
  assign pair_avail = !resp_empty && !pend_empty;

  // Opaque tag in the response matches the pending epoch anyway
  assign stale    = (pend_data.epoch != epoch);
  assign seq_full = (live_cnt == CNT_W'(NUM_SEQ));

  // Squash cycle still sees the old epoch, so hide the head pair
  assign d_val  = pair_avail && !stale && !squash_val && !seq_full;
  assign accept = d_val && d_rdy;

  // Drop stale pairs, or retire the one decode just took
  assign pop = pair_avail && (stale || accept);

  assign d_msg.inst    = resp_data.data;
  assign d_msg.pc      = pend_data.pc;
  assign d_msg.seq_num = tail_q;

  // ----------------------------------------------------------
  // Live sequence number tracking
  // ----------------------------------------------------------

  // Squashing number stays live, everything after it goes
  assign sq_dist = squash.seq_num - head_q;
  assign live_sq = CNT_W'(sq_dist) + CNT_W'(1);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      head_q   <= '0;
      tail_q   <= '0;
      live_cnt <= '0;
    end else begin
      // In-order commit, head follows the committed number
      if (commit_val) begin
        head_q <= commit_seq_num + 1'b1;
      end
      if (squash_val) begin
        // No accept can happen in this cycle
        tail_q   <= squash.seq_num + 1'b1;
        live_cnt <= live_sq - CNT_W'(commit_val);
      end else begin
        if (accept) begin
          tail_q <= tail_q + 1'b1;
        end
        live_cnt <= live_cnt + CNT_W'(accept) - CNT_W'(commit_val);
      end
    end
  end

endmodule

/* rtl/fetch_unit.sv */
// ----------------------------------------------------------
// Instruction fetch unit top
// Memory must answer in order, one word per request
// Responses are accepted while the response queue has room
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_unit (
  input  logic                   clk,
  input  logic                   rst_n,
  output mem_pkg::mem_req_t      mem_req,
  output logic                   mem_req_val,
  input  logic                   mem_req_rdy,
  input  mem_pkg::mem_resp_t     mem_resp,
  input  logic                   mem_resp_val,
  output logic                   mem_resp_rdy,
  output fetch_pkg::f_d_msg_t    d_msg,
  output logic                   d_val,
  input  logic                   d_rdy,
  input  logic                   commit_val,
  input  fetch_pkg::seq_num_t    commit_seq_num,
  input  logic                   squash_val,
  input  fetch_pkg::squash_msg_t squash
);

  import mem_pkg::*;
  import fetch_pkg::*;

  // Pending PC queue
  logic      pend_push;
  pending_t  pend_in;
  pending_t  pend_out;
  logic      pend_full;
  logic      pend_empty;

  // Response queue
  mem_resp_t resp_out;
  logic      resp_full;
  logic      resp_empty;

  // Pair pop and current epoch
  logic      pair_pop;
  epoch_t    epoch;

  // Same depth as the pending queue, so this never stalls in use
  assign mem_resp_rdy = !resp_full;

  // ----------------------------------------------------------
  // Request generation
  // ----------------------------------------------------------

  fetch_pc_gen u_pc_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_req     (mem_req),
    .mem_req_val (mem_req_val),
    .mem_req_rdy (mem_req_rdy),
    .pend_full   (pend_full),
    .pend_push   (pend_push),
    .pend_data   (pend_in),
    .squash_val  (squash_val),
    .squash      (squash),
    .epoch       (epoch)
  );

  // ----------------------------------------------------------
  // In-order queues
  // ----------------------------------------------------------

  fetch_queue #(
    .payload_t (pending_t),
    .DEPTH     (`FETCH_MAX_IN_FLIGHT)
  ) u_pend_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (pend_push),
    .push_data (pend_in),
    .pop       (pair_pop),
    .pop_data  (pend_out),
    .empty     (pend_empty),
    .full      (pend_full)
  );

  fetch_queue #(
    .payload_t (mem_resp_t),
    .DEPTH     (`FETCH_MAX_IN_FLIGHT)
  ) u_resp_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (mem_resp_val && mem_resp_rdy),
    .push_data (mem_resp),
    .pop       (pair_pop),
    .pop_data  (resp_out),
    .empty     (resp_empty),
    .full      (resp_full)
  );

  // ----------------------------------------------------------
  // Delivery to decode
  // ----------------------------------------------------------

  fetch_deliver u_deliver (
    .clk            (clk),
    .rst_n          (rst_n),
    .resp_empty     (resp_empty),
    .pend_empty     (pend_empty),
    .resp_data      (resp_out),
    .pend_data      (pend_out),
    .pop            (pair_pop),
    .epoch          (epoch),
    .d_msg          (d_msg),
    .d_val          (d_val),
    .d_rdy          (d_rdy),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .squash_val     (squash_val),
    .squash         (squash)
  );

endmodule

/* dv/fetch_mem_model.sv */
// ----------------------------------------------------------
// Instruction memory model, answers strictly in order
// Word at any address is the bitwise inverse of the address
// Random stalls on both the request and response side
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_mem_model (
  input  logic               clk,
  input  logic               rst_n,
  input  mem_pkg::mem_req_t  mem_req,
  input  logic               mem_req_val,
  output logic               mem_req_rdy,
  output mem_pkg::mem_resp_t mem_resp,
  output logic               mem_resp_val,
  input  logic               mem_resp_rdy
);

  import mem_pkg::*;

  // Accepted requests, oldest first
  mem_req_t req_q[$];
  // Response handshake seen at the last rising edge
  logic     resp_fire;

  initial begin
    mem_req_rdy  = 1'b0;
    mem_resp_val = 1'b0;
    mem_resp     = '0;
    resp_fire    = 1'b0;
  end

  // ----------------------------------------------------------
  // Sample handshakes on the rising edge, drive on the falling
  // ----------------------------------------------------------

  always begin
    @(posedge clk);
    resp_fire = rst_n && mem_resp_val && mem_resp_rdy;
    if (!rst_n) begin
      req_q.delete();
    end else begin
      if (resp_fire) begin
        void'(req_q.pop_front());
      end
      if (mem_req_val && mem_req_rdy) begin
        req_q.push_back(mem_req);
      end
    end
    @(negedge clk);
    // Withhold ready about one cycle in four
    mem_req_rdy = rst_n && ($urandom_range(3) != 0);
    // A response waiting for rdy stays put
    if (resp_fire || !mem_resp_val || !rst_n) begin
      mem_resp_val = rst_n && (req_q.size() > 0) && ($urandom_range(2) != 0);
      if (mem_resp_val) begin
        mem_resp.data   = ~req_q[0].addr;
        mem_resp.opaque = req_q[0].opaque;
      end
    end
  end

endmodule

/* dv/fetch_unit_checker.sv */
// ----------------------------------------------------------
// Port checks for the fetch unit attached by bind
// Expects in-order commits and squashes on live numbers only
// Memory data rule assumed to be the inverse of the address
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_unit_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  mem_pkg::mem_req_t      mem_req,
  input  logic                   mem_req_val,
  input  logic                   mem_req_rdy,
  input  logic                   mem_resp_val,
  input  logic                   mem_resp_rdy,
  input  fetch_pkg::f_d_msg_t    d_msg,
  input  logic                   d_val,
  input  logic                   d_rdy,
  input  logic                   commit_val,
  input  logic                   squash_val,
  input  fetch_pkg::squash_msg_t squash
);

  import fetch_pkg::*;

  localparam int NUM_SEQ = 2 ** `FETCH_SEQ_NUM_BITS;

  int          err_cnt = 0;
  // Reference state
  int          live_q;
  int          in_flight;
  seq_num_t    head_q;
  seq_num_t    exp_seq;
  logic [31:0] exp_pc;
  logic        first_req;
  logic        acc;
  logic        req_fire;
  logic        resp_fire;

  assign acc       = d_val && d_rdy;
  assign req_fire  = mem_req_val && mem_req_rdy;
  assign resp_fire = mem_resp_val && mem_resp_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      live_q    <= 0;
      in_flight <= 0;
      head_q    <= '0;
      exp_seq   <= '0;
      exp_pc    <= `FETCH_RESET_PC;
      first_req <= 1'b1;
    end else begin
      in_flight <= in_flight + int'(req_fire) - int'(resp_fire);
      if (req_fire) begin
        first_req <= 1'b0;
      end
      // Commit always retires the oldest live number
      if (commit_val) begin
        head_q <= head_q + 1'b1;
      end
      if (squash_val) begin
        // Squashing number stays live and fetch redirects to target
        live_q  <= int'(seq_num_t'(squash.seq_num - head_q)) + 1 - int'(commit_val);
        exp_pc  <= squash.target;
        exp_seq <= squash.seq_num + 1'b1;
      end else begin
        live_q <= live_q + int'(acc) - int'(commit_val);
        if (acc) begin
          exp_pc  <= exp_pc + 32'd4;
          exp_seq <= exp_seq + 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------
  // Decode channel
  // ----------------------------------------------------------

  assert property (@(posedge clk) disable iff (!rst_n) acc |-> d_msg.inst == ~d_msg.pc)
    else begin
      err_cnt++;
      $error("FAILED d_msg.inst exp %h got %h", ~$sampled(d_msg.pc), $sampled(d_msg.inst));
    end

  assert property (@(posedge clk) disable iff (!rst_n) acc |-> d_msg.pc == exp_pc)
    else begin
      err_cnt++;
      $error("FAILED d_msg.pc exp %h got %h", $sampled(exp_pc), $sampled(d_msg.pc));
    end

  assert property (@(posedge clk) disable iff (!rst_n) acc |-> d_msg.seq_num == exp_seq)
    else begin
      err_cnt++;
      $error("FAILED d_msg.seq_num exp %h got %h", $sampled(exp_seq), $sampled(d_msg.seq_num));
    end

  // Nothing may go out while every number is live
  assert property (@(posedge clk) disable iff (!rst_n) acc |-> live_q < NUM_SEQ)
    else begin
      err_cnt++;
      $error("FAILED d_val %h with live count %h", $sampled(d_val), $sampled(live_q));
    end

  // Only a squash may withdraw a stalled message
  assert property (@(posedge clk) disable iff (!rst_n)
    d_val && !d_rdy && !squash_val |=> squash_val || (d_val && $stable(d_msg)))
    else begin
      err_cnt++;
      $error("FAILED d_val %h d_msg %h changed while stalled", $sampled(d_val), $sampled(d_msg));
    end

  // ----------------------------------------------------------
  // Memory side and reset
  // ----------------------------------------------------------

  assert property (@(posedge clk) disable iff (!rst_n)
    mem_req_val && !mem_req_rdy |=> squash_val || (mem_req_val && $stable(mem_req)))
    else begin
      err_cnt++;
      $error("FAILED mem_req_val %h mem_req %h changed while stalled",
             $sampled(mem_req_val), $sampled(mem_req));
    end

  assert property (@(posedge clk) disable iff (!rst_n) in_flight <= `FETCH_MAX_IN_FLIGHT)
    else begin
      err_cnt++;
      $error("FAILED in_flight max %h got %h", `FETCH_MAX_IN_FLIGHT, $sampled(in_flight));
    end

  // Response queue keeps room for every outstanding read
  assert property (@(posedge clk) disable iff (!rst_n) mem_resp_val |-> mem_resp_rdy)
    else begin
      err_cnt++;
      $error("FAILED mem_resp_rdy exp %h got %h", 1'b1, $sampled(mem_resp_rdy));
    end

  assert property (@(posedge clk) !rst_n |-> !mem_req_val && !d_val && mem_resp_rdy)
    else begin
      err_cnt++;
      $error("FAILED mem_req_val %h d_val %h mem_resp_rdy %h in reset",
             $sampled(mem_req_val), $sampled(d_val), $sampled(mem_resp_rdy));
    end

  // First request goes out at the reset PC in epoch 0
  assert property (@(posedge clk) disable iff (!rst_n)
    req_fire && first_req |-> mem_req.addr == `FETCH_RESET_PC && mem_req.opaque == '0)
    else begin
      err_cnt++;
      $error("FAILED mem_req exp %h got %h", {`FETCH_RESET_PC, `FETCH_OPAQ_BITS'(0)},
             $sampled(mem_req));
    end

endmodule

bind fetch_unit fetch_unit_checker u_checker (.*);

/* dv/fetch_unit_tb.sv */
// ----------------------------------------------------------
// Fetch unit testbench, checks live in the bound checker
// Squashes are spaced so stale epochs never wrap
// ----------------------------------------------------------
`timescale 1ns/1ps
`include "fetch_cfg.svh"

module fetch_unit_tb;

  import mem_pkg::*;
  import fetch_pkg::*;

  localparam int NUM_SEQ = 2 ** `FETCH_SEQ_NUM_BITS;

  logic        clk;
  logic        rst_n;
  mem_req_t    mem_req;
  logic        mem_req_val;
  logic        mem_req_rdy;
  mem_resp_t   mem_resp;
  logic        mem_resp_val;
  logic        mem_resp_rdy;
  f_d_msg_t    d_msg;
  logic        d_val;
  logic        d_rdy;
  logic        commit_val;
  seq_num_t    commit_seq_num;
  logic        squash_val;
  squash_msg_t squash;

  int          timeouts;
  int          errors;
  int          acc_cnt;
  // Cycles since the last squash
  int          sq_gap;

  always #5 clk = ~clk;

  fetch_unit DUT (.*);

  fetch_mem_model u_mem (.*);

  // Decode accepts, used by the waits
  always @(posedge clk) begin
    if (rst_n && d_val && d_rdy) begin
      acc_cnt <= acc_cnt + 1;
    end
  end

  // ----------------------------------------------------------
  // One falling edge of stimulus
  // ----------------------------------------------------------

  task automatic drive_cycle(input bit allow_commit, input bit allow_squash);
    int       live;
    seq_num_t head;
    @(negedge clk);
    live       = DUT.u_checker.live_q;
    head       = DUT.u_checker.head_q;
    commit_val = 1'b0;
    squash_val = 1'b0;
    d_rdy      = ($urandom_range(3) != 0);
    sq_gap++;
    if (allow_squash && live > 0 && sq_gap > 30 && $urandom_range(15) == 0) begin
      // Any live number, random word-aligned target
      squash_val     = 1'b1;
      squash.seq_num = head + seq_num_t'($urandom_range(live - 1));
      squash.target  = $urandom() & 32'hffff_fffc;
      sq_gap         = 0;
    end else if (allow_commit && live > 0 && $urandom_range(2) == 0) begin
      commit_val     = 1'b1;
      commit_seq_num = head;
    end
  endtask

  task automatic wait_accepts(input int cnt);
    int goal;
    int n;
    goal = acc_cnt + cnt;
    n    = 0;
    while (acc_cnt < goal && n < 3000) begin
      drive_cycle(1'b1, 1'b1);
      n++;
    end
    if (acc_cnt < goal) begin
      timeouts++;
      $display("ERROR: decode saw too few instructions before the timeout");
    end
  endtask

  // No commits, deliveries run until every number is live
  task automatic fill_seq_space();
    int n;
    n = 0;
    while (DUT.u_checker.live_q < NUM_SEQ && n < 500) begin
      drive_cycle(1'b0, 1'b0);
      n++;
    end
    if (DUT.u_checker.live_q < NUM_SEQ) begin
      timeouts++;
      $display("ERROR: sequence space never filled before the timeout");
    end
  endtask

  initial begin
    void'($urandom(32'h4764f476));
    clk            = 1'b0;
    rst_n          = 1'b0;
    d_rdy          = 1'b0;
    commit_val     = 1'b0;
    commit_seq_num = '0;
    squash_val     = 1'b0;
    squash         = '0;
    timeouts       = 0;
    acc_cnt        = 0;
    sq_gap         = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Random traffic with commits and squashes
    wait_accepts(200);
    fill_seq_space();
    // Stay full for a while, decode keeps asking
    repeat (10) drive_cycle(1'b0, 1'b0);
    wait_accepts(60);

    @(negedge clk);
    commit_val = 1'b0;
    squash_val = 1'b0;
    errors     = DUT.u_checker.err_cnt;
    $display("Checker errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* fetch_unit.f */
+incdir+rtl
rtl/mem_pkg.sv
rtl/fetch_pkg.sv
rtl/fetch_queue.sv
rtl/fetch_pc_gen.sv
rtl/fetch_deliver.sv
rtl/fetch_unit.sv
dv/fetch_mem_model.sv
dv/fetch_unit_checker.sv
dv/fetch_unit_tb.sv
